//--- common/overlay_config.svh
// overlay timing and register map
`ifndef OVERLAY_CONFIG_SVH
`define OVERLAY_CONFIG_SVH

// horizontal timing in pixel clocks
`define H_ACTIVE        64
`define H_FRONT         4
`define H_SYNC          8
`define H_BACK          4
`define H_TOTAL         (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)
`define H_SYNC_START    (`H_ACTIVE + `H_FRONT)
`define H_SYNC_END      (`H_SYNC_START + `H_SYNC)

// vertical timing in lines
`define V_ACTIVE        48
`define V_FRONT         2
`define V_SYNC          2
`define V_BACK          3
`define V_TOTAL         (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)
`define V_SYNC_START    (`V_ACTIVE + `V_FRONT)
`define V_SYNC_END      (`V_SYNC_START + `V_SYNC)

// datapath widths
`define COORD_X_BITS    10
`define COORD_Y_BITS    10
`define PIXEL_BITS      24
`define REG_ADDR_BITS   5
`define REG_DATA_BITS   24

// layers and pipeline
`define LAYER_COUNT     4
`define PIPE_DEPTH      3          // position to pixel
`define MIX_TAP         2          // position to mixer input

// register map with five words per layer
`define REG_STRIDE      5
`define REG_OFS_XSTART  0
`define REG_OFS_XEND    1
`define REG_OFS_YSTART  2
`define REG_OFS_YEND    3
`define REG_OFS_COLOUR  4
`define REG_BACKGROUND  20
`define REG_ENABLE_BASE 21         // one word per layer in bit 0

`endif

//--- common/overlayPkg.sv
// rectangle overlay shared types

`include "overlay_config.svh"

package overlayPkg;

    //------------------------------------------------------------
    // raster coordinates
    //------------------------------------------------------------

    // horizontal pixel column
    typedef logic [`COORD_X_BITS-1:0] coordX_t;

    // vertical line number
    typedef logic [`COORD_Y_BITS-1:0] coordY_t;

    //------------------------------------------------------------
    // colour
    //------------------------------------------------------------

    // packed rgb with 8 bits per channel by default
    typedef logic [`PIXEL_BITS-1:0] pixel_t;

    //------------------------------------------------------------
    // register write port
    //------------------------------------------------------------

    // word address into the settings map
    typedef logic [`REG_ADDR_BITS-1:0] regAddr_t;

    // write data wide enough for a whole colour
    typedef logic [`REG_DATA_BITS-1:0] regData_t;

endpackage

//--- verilog/videoTiming.sv
// raster timing generator
`timescale 1ns/1ps
`include "overlay_config.svh"

module videoTiming (
    input  logic                iClk,
    input  logic                arstN,
    output overlayPkg::coordX_t hPos,       // current column
    output overlayPkg::coordY_t vPos,       // current line
    output logic                frameEnd,   // last position of the frame
    output logic                deMix,      // active flag at the mixer tap
    output logic                de,
    output logic                hSync,
    output logic                vSync
);
    import overlayPkg::*;

    coordX_t                hCnt;
    coordY_t                vCnt;
    logic                   lineEnd;
    logic                   activeNow;
    logic                   hSyncNow;
    logic                   vSyncNow;
    logic [`PIPE_DEPTH-1:0] deDly;          // [0] is one cycle late
    logic [`PIPE_DEPTH-1:0] hsDly;
    logic [`PIPE_DEPTH-1:0] vsDly;

    //------------------------------------------------------------
    // raster counters
    //------------------------------------------------------------
    assign lineEnd  = (hCnt == coordX_t'(`H_TOTAL - 1));
    assign frameEnd = lineEnd && (vCnt == coordY_t'(`V_TOTAL - 1));

    always_ff @(posedge iClk or negedge arstN)
    begin
        if (!arstN)
        begin
            hCnt <= '0;
            vCnt <= '0;
        end
        else if (lineEnd)
        begin
            hCnt <= '0;                     // wrap line
            if (vCnt == coordY_t'(`V_TOTAL - 1))
                vCnt <= '0;                 // wrap frame
            else
                vCnt <= vCnt + 1'b1;
        end
        else
        begin
            hCnt <= hCnt + 1'b1;
        end
    end

    assign hPos = hCnt;
    assign vPos = vCnt;

    //------------------------------------------------------------
    // level decode
    //------------------------------------------------------------
    assign activeNow = (hCnt < coordX_t'(`H_ACTIVE)) && (vCnt < coordY_t'(`V_ACTIVE));
    assign hSyncNow  = (hCnt >= coordX_t'(`H_SYNC_START))
                    && (hCnt < coordX_t'(`H_SYNC_END));
    // whole lines of vsync
    assign vSyncNow  = (vCnt >= coordY_t'(`V_SYNC_START))
                    && (vCnt < coordY_t'(`V_SYNC_END));

    //------------------------------------------------------------
    // delay line matching layer and mixer latency
    //------------------------------------------------------------
    always_ff @(posedge iClk or negedge arstN)
    begin
        if (!arstN)
        begin
            deDly <= '0;
            hsDly <= '0;
            vsDly <= '0;
        end
        else
        begin
            deDly <= {deDly[`PIPE_DEPTH-2:0], activeNow};
            hsDly <= {hsDly[`PIPE_DEPTH-2:0], hSyncNow};
            vsDly <= {vsDly[`PIPE_DEPTH-2:0], vSyncNow};
        end
    end

    assign deMix = deDly[`MIX_TAP-1];       // lines up with layer hits
    assign de    = deDly[`PIPE_DEPTH-1];    // lines up with pixel
    assign hSync = hsDly[`PIPE_DEPTH-1];
    assign vSync = vsDly[`PIPE_DEPTH-1];

endmodule

//--- overlay/rectLayer.sv
// rectangle hit test layer
`timescale 1ns/1ps

module rectLayer (
    input  logic                iClk,
    input  logic                arstN,
    input  overlayPkg::coordX_t hPos,
    input  overlayPkg::coordY_t vPos,
    input  overlayPkg::coordX_t xStart,     // inclusive bounds
    input  overlayPkg::coordX_t xEnd,
    input  overlayPkg::coordY_t yStart,
    input  overlayPkg::coordY_t yEnd,
    input  overlayPkg::pixel_t  colour,
    input  logic                enable,
    output logic                hit,        // two cycles after position
    output overlayPkg::pixel_t  layerColour
);
    import overlayPkg::*;

    logic [3:0] bound;                      // stage 1 compare results
    logic       enStage;
    pixel_t     colourPipe [2];             // rides along with the hit

    //------------------------------------------------------------
    // colour shift register
    //------------------------------------------------------------
    always_ff @(posedge iClk or negedge arstN)
    begin
        if (!arstN)
        begin
            colourPipe <= '{default: '0};
        end
        else
        begin
            colourPipe[0] <= colour;
            colourPipe[1] <= colourPipe[0];
        end
    end

    assign layerColour = colourPipe[1];

    //------------------------------------------------------------
    // stage 1 bound compares
    //------------------------------------------------------------
    always_ff @(posedge iClk or negedge arstN)
    begin
        if (!arstN)
        begin
            bound   <= '0;
            enStage <= 1'b0;
        end
        else
        begin
            bound[0] <= (xStart <= hPos);   // left edge
            bound[1] <= (hPos <= xEnd);     // right edge
            bound[2] <= (yStart <= vPos);   // top
            bound[3] <= (vPos <= yEnd);     // bottom
            enStage  <= enable;
        end
    end

    //------------------------------------------------------------
    // stage 2 combines the compares
    //------------------------------------------------------------
    always_ff @(posedge iClk or negedge arstN)
    begin
        if (!arstN)
            hit <= 1'b0;
        else
            hit <= (&bound) & enStage;      // start > end never hits
    end

endmodule

//--- overlay/layerRegs.sv
// layer settings register bank
`timescale 1ns/1ps
`include "overlay_config.svh"

module layerRegs (
    input  logic                 iClk,
    input  logic                 arstN,
    input  logic                 regWe,         // one write per cycle high
    input  overlayPkg::regAddr_t regAddr,
    input  overlayPkg::regData_t regData,
    input  logic                 frameEnd,      // shadow update strobe
    output overlayPkg::coordX_t  xStart [`LAYER_COUNT],
    output overlayPkg::coordX_t  xEnd   [`LAYER_COUNT],
    output overlayPkg::coordY_t  yStart [`LAYER_COUNT],
    output overlayPkg::coordY_t  yEnd   [`LAYER_COUNT],
    output overlayPkg::pixel_t   colour [`LAYER_COUNT],
    output logic                 enable [`LAYER_COUNT],
    output overlayPkg::pixel_t   background
);
    import overlayPkg::*;

    // staged copy written by the register port
    coordX_t stXStart [`LAYER_COUNT];
    coordX_t stXEnd   [`LAYER_COUNT];
    coordY_t stYStart [`LAYER_COUNT];
    coordY_t stYEnd   [`LAYER_COUNT];
    pixel_t  stColour [`LAYER_COUNT];
    logic    stEnable [`LAYER_COUNT];
    pixel_t  stBackground;

    //------------------------------------------------------------
    // write decode into staged copy
    //------------------------------------------------------------
    always_ff @(posedge iClk or negedge arstN)
    begin
        if (!arstN)
        begin
            stXStart     <= '{default: '0};
            stXEnd       <= '{default: '0};
            stYStart     <= '{default: '0};
            stYEnd       <= '{default: '0};
            stColour     <= '{default: '0};
            stEnable     <= '{default: 1'b0};
            stBackground <= '0;
        end
        else if (regWe)
        begin
            for (int n = 0; n < `LAYER_COUNT; n++)
            begin
                if (regAddr == regAddr_t'(n * `REG_STRIDE + `REG_OFS_XSTART))
                    stXStart[n] <= coordX_t'(regData);
                if (regAddr == regAddr_t'(n * `REG_STRIDE + `REG_OFS_XEND))
                    stXEnd[n] <= coordX_t'(regData);
                if (regAddr == regAddr_t'(n * `REG_STRIDE + `REG_OFS_YSTART))
                    stYStart[n] <= coordY_t'(regData);
                if (regAddr == regAddr_t'(n * `REG_STRIDE + `REG_OFS_YEND))
                    stYEnd[n] <= coordY_t'(regData);
                if (regAddr == regAddr_t'(n * `REG_STRIDE + `REG_OFS_COLOUR))
                    stColour[n] <= pixel_t'(regData);
                if (regAddr == regAddr_t'(`REG_ENABLE_BASE + n))
                    stEnable[n] <= regData[0];      // bit 0 only
            end
            if (regAddr == regAddr_t'(`REG_BACKGROUND))
                stBackground <= pixel_t'(regData);
            // unmapped addresses fall through
        end
    end

    //------------------------------------------------------------
    // per-frame shadow copy
    //------------------------------------------------------------
    // same-cycle write only reaches the staged side
    always_ff @(posedge iClk or negedge arstN)
    begin
        if (!arstN)
        begin
            xStart     <= '{default: '0};
            xEnd       <= '{default: '0};
            yStart     <= '{default: '0};
            yEnd       <= '{default: '0};
            colour     <= '{default: '0};
            enable     <= '{default: 1'b0};
            background <= '0;
        end
        else if (frameEnd)
        begin
            xStart     <= stXStart;
            xEnd       <= stXEnd;
            yStart     <= stYStart;
            yEnd       <= stYEnd;
            colour     <= stColour;
            enable     <= stEnable;
            background <= stBackground;
        end
    end

endmodule

//--- overlay/layerMixer.sv
// priority layer mixer
`timescale 1ns/1ps
`include "overlay_config.svh"

module layerMixer (
    input  logic                     iClk,
    input  logic                     arstN,
    input  logic [`LAYER_COUNT-1:0]  hit,           // one per layer
    input  overlayPkg::pixel_t       layerColour [`LAYER_COUNT],
    input  overlayPkg::pixel_t       background,
    input  logic                     deMix,         // active area aligned with hits
    output overlayPkg::pixel_t       pixel
);
    import overlayPkg::*;

    pixel_t choice;                         // winning colour this cycle

    //------------------------------------------------------------
    // priority select
    //------------------------------------------------------------
    // later layers overwrite earlier ones
    // so the highest index wins
    always_comb
    begin
        choice = background;
        for (int i = 0; i < `LAYER_COUNT; i++)
        begin
            if (hit[i])
                choice = layerColour[i];
        end
    end

    //------------------------------------------------------------
    // output register with blanking
    //------------------------------------------------------------
    always_ff @(posedge iClk or negedge arstN)
    begin
        if (!arstN)
        begin
            pixel <= '0;
        end
        else if (!deMix)
        begin
            pixel <= '0;                    // black outside active area
        end
        else
        begin
            pixel <= choice;
        end
    end

    // blanking also clips rectangles that run past the raster
    // since hits beyond column 63 or line 47 never reach the output

endmodule

//--- verilog/rectOverlayTop.sv
// rectangle overlay top level
`timescale 1ns/1ps
`include "overlay_config.svh"

module rectOverlayTop (
    input  logic                 iClk,
    input  logic                 arstN,
    input  logic                 regWe,
    input  overlayPkg::regAddr_t regAddr,
    input  overlayPkg::regData_t regData,
    output overlayPkg::pixel_t   pixel,     // three cycles after position
    output logic                 de,
    output logic                 hSync,
    output logic                 vSync
);
    import overlayPkg::*;

    // raster
    coordX_t                 hPos;
    coordY_t                 vPos;
    logic                    frameEnd;
    logic                    deMix;

    // active layer settings
    coordX_t                 xStart [`LAYER_COUNT];
    coordX_t                 xEnd   [`LAYER_COUNT];
    coordY_t                 yStart [`LAYER_COUNT];
    coordY_t                 yEnd   [`LAYER_COUNT];
    pixel_t                  colour [`LAYER_COUNT];
    logic                    enable [`LAYER_COUNT];
    pixel_t                  background;

    // layer results
    logic [`LAYER_COUNT-1:0] hit;
    pixel_t                  layerColour [`LAYER_COUNT];

    //------------------------------------------------------------
    // timing and settings
    //------------------------------------------------------------
    videoTiming u_timing (
        .iClk     (iClk),
        .arstN    (arstN),
        .hPos     (hPos),
        .vPos     (vPos),
        .frameEnd (frameEnd),
        .deMix    (deMix),
        .de       (de),
        .hSync    (hSync),
        .vSync    (vSync)
    );

    layerRegs u_regs (
        .iClk       (iClk),
        .arstN      (arstN),
        .regWe      (regWe),
        .regAddr    (regAddr),
        .regData    (regData),
        .frameEnd   (frameEnd),
        .xStart     (xStart),
        .xEnd       (xEnd),
        .yStart     (yStart),
        .yEnd       (yEnd),
        .colour     (colour),
        .enable     (enable),
        .background (background)
    );

    //------------------------------------------------------------
    // one layer per rectangle
    //------------------------------------------------------------
    for (genvar g = 0; g < `LAYER_COUNT; g++)
    begin : gLayer
        rectLayer u_layer (
            .iClk        (iClk),
            .arstN       (arstN),
            .hPos        (hPos),
            .vPos        (vPos),
            .xStart      (xStart[g]),
            .xEnd        (xEnd[g]),
            .yStart      (yStart[g]),
            .yEnd        (yEnd[g]),
            .colour      (colour[g]),
            .enable      (enable[g]),
            .hit         (hit[g]),
            .layerColour (layerColour[g])
        );
    end

    layerMixer u_mixer (
        .iClk        (iClk),
        .arstN       (arstN),
        .hit         (hit),
        .layerColour (layerColour),
        .background  (background),
        .deMix       (deMix),
        .pixel       (pixel)
    );

endmodule

//--- bench/rectOverlayTb.sv
// rectangle overlay testbench
`timescale 1ns/1ps
`include "overlay_config.svh"

module rectOverlayTb;
    import overlayPkg::*;

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int CYCLE_LIMIT  = 4 * FRAME_CYCLES + 2400;  // four frames plus reset and slack

    logic     iClk;
    logic     arstN;
    logic     regWe;
    regAddr_t regAddr;
    regData_t regData;
    pixel_t   pixel;
    logic     de;
    logic     hSync;
    logic     vSync;

    // bench copy of the register bank
    coordX_t  stXs [`LAYER_COUNT];
    coordX_t  stXe [`LAYER_COUNT];
    coordY_t  stYs [`LAYER_COUNT];
    coordY_t  stYe [`LAYER_COUNT];
    pixel_t   stCol [`LAYER_COUNT];
    logic     stEn [`LAYER_COUNT];
    pixel_t   stBg;
    coordX_t  actXs [`LAYER_COUNT];
    coordX_t  actXe [`LAYER_COUNT];
    coordY_t  actYs [`LAYER_COUNT];
    coordY_t  actYe [`LAYER_COUNT];
    pixel_t   actCol [`LAYER_COUNT];
    logic     actEn [`LAYER_COUNT];
    pixel_t   actBg;

    int       seed = 32'h4a916ccc;
    int       errCount = 0;
    int       checkCount = 0;
    int       cycleCount = 0;
    int       framesSeen;
    int       x;                            // raster position seen at the output
    int       y;
    int       hsLen;
    logic     prevDe;
    logic     prevHs;
    logic     prevVs;

    rectOverlayTop u_dut (
        .iClk    (iClk),
        .arstN   (arstN),
        .regWe   (regWe),
        .regAddr (regAddr),
        .regData (regData),
        .pixel   (pixel),
        .de      (de),
        .hSync   (hSync),
        .vSync   (vSync)
    );

    always #4 iClk = ~iClk;                 // 8 ns period

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    // highest enabled layer covering (x, y) or else background
    function automatic pixel_t expectedPixel(input int px, input int py);
        pixel_t c;
        int     n;
        c = actBg;
        for (n = 0; n < `LAYER_COUNT; n++)
        begin
            if (actEn[n] && px >= int'(actXs[n]) && px <= int'(actXe[n])
                && py >= int'(actYs[n]) && py <= int'(actYe[n]))
                c = actCol[n];
        end
        return c;
    endfunction

    function automatic pixel_t randomColour();
        randomColour = pixel_t'($random(seed)) | pixel_t'(1);   // never black
    endfunction

    // one strobe from a falling edge to the next
    task automatic writeReg(input int addr, input logic [31:0] data);
        int n;
        n = addr / `REG_STRIDE;
        regWe   = 1'b1;
        regAddr = regAddr_t'(addr);
        regData = regData_t'(data);
        if (addr < `REG_BACKGROUND)
        begin
            case (addr % `REG_STRIDE)
                `REG_OFS_XSTART: stXs[n] = coordX_t'(data);
                `REG_OFS_XEND:   stXe[n] = coordX_t'(data);
                `REG_OFS_YSTART: stYs[n] = coordY_t'(data);
                `REG_OFS_YEND:   stYe[n] = coordY_t'(data);
                default:         stCol[n] = pixel_t'(data);
            endcase
        end
        else if (addr == `REG_BACKGROUND)
            stBg = pixel_t'(data);
        else if (addr >= `REG_ENABLE_BASE && addr < `REG_ENABLE_BASE + `LAYER_COUNT)
            stEn[addr - `REG_ENABLE_BASE] = data[0];   // only bit 0 counts
        @(negedge iClk);
        regWe = 1'b0;
    endtask

    task automatic setLayer(input int n, input int xs, input int xe, input int ys,
                            input int ye, input pixel_t col);
        writeReg(n * `REG_STRIDE + `REG_OFS_XSTART, xs);
        writeReg(n * `REG_STRIDE + `REG_OFS_XEND, xe);
        writeReg(n * `REG_STRIDE + `REG_OFS_YSTART, ys);
        writeReg(n * `REG_STRIDE + `REG_OFS_YEND, ye);
        writeReg(n * `REG_STRIDE + `REG_OFS_COLOUR, col);
    endtask

    // ------------------------------------------------------------
    // output monitor and compare
    // ------------------------------------------------------------
    always @(posedge iClk)
    begin
        if (!arstN)
        begin
            x = 0;
            y = 0;
            hsLen = 0;
            framesSeen = 0;
            prevDe = 1'b0;
            prevHs = 1'b0;
            prevVs = 1'b0;
        end
        else
        begin
            checkCount++;
            if (de)
            begin
                if (pixel !== expectedPixel(x, y))
                begin
                    $display("CHECK FAILED at %0t: pixel (%0d,%0d) is %06h, expected %06h",
                             $time, x, y, pixel, expectedPixel(x, y));
                    errCount++;
                end
                x++;
            end
            else if (pixel !== '0)          // blanked outside active area
            begin
                $display("CHECK FAILED at %0t: pixel %06h while de is low", $time, pixel);
                errCount++;
            end
            if (prevDe && !de)              // line done
            begin
                if (x != `H_ACTIVE)
                begin
                    $display("CHECK FAILED at %0t: line %0d had %0d de cycles",
                             $time, y, x);
                    errCount++;
                end
                x = 0;
                y++;
            end
            if (hSync)
                hsLen++;
            if (prevHs && !hSync)
            begin
                if (hsLen != `H_SYNC)
                begin
                    $display("CHECK FAILED at %0t: hsync pulse of %0d cycles", $time, hsLen);
                    errCount++;
                end
                hsLen = 0;
            end
            if (vSync && !prevVs)
            begin
                if (y != `V_ACTIVE)
                begin
                    $display("CHECK FAILED at %0t: frame had %0d active lines", $time, y);
                    errCount++;
                end
                framesSeen++;
            end
            if (vSync)
                y = 0;
            if (prevVs && !vSync)           // model shadow update ahead of frameEnd
            begin
                actXs  = stXs;
                actXe  = stXe;
                actYs  = stYs;
                actYe  = stYe;
                actCol = stCol;
                actEn  = stEn;
                actBg  = stBg;
            end
            prevDe = de;
            prevHs = hSync;
            prevVs = vSync;
        end
    end

    // run limit
    always @(posedge iClk)
    begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT)
        begin
            $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial
    begin
        iClk    = 1'b0;
        arstN   = 1'b0;
        regWe   = 1'b0;
        regAddr = '0;
        regData = '0;
        for (int n = 0; n < `LAYER_COUNT; n++)
        begin
            stXs[n]  = '0;
            stXe[n]  = '0;
            stYs[n]  = '0;
            stYe[n]  = '0;
            stCol[n] = '0;
            stEn[n]  = 1'b0;
        end
        stBg   = '0;
        actXs  = stXs;
        actXe  = stXe;
        actYs  = stYs;
        actYe  = stYe;
        actCol = stCol;
        actEn  = stEn;
        actBg  = stBg;

        repeat (16)
        begin
            @(negedge iClk);
            if (de !== 1'b0 || hSync !== 1'b0 || vSync !== 1'b0 || pixel !== '0)
            begin
                $display("CHECK FAILED at %0t: outputs not idle in reset", $time);
                errCount++;
            end
        end
        arstN = 1'b1;
        while (de !== 1'b1)                 // quiet until the first active line
        begin
            @(negedge iClk);
            if (hSync !== 1'b0 || vSync !== 1'b0)
            begin
                $display("CHECK FAILED at %0t: sync before first active line", $time);
                errCount++;
            end
        end

        // frame 1 runs with no writes and frame 2 gets a single layer
        @(posedge vSync);
        @(negedge iClk);
        writeReg(`REG_BACKGROUND, randomColour());
        setLayer(0, 10, 30, 5, 20, randomColour());
        writeReg(`REG_ENABLE_BASE + 0, 1);
        writeReg(27, 32'h00ABCDEF);         // unmapped

        // frame 3 overlaps layers 1 and 3 under a disabled full-screen layer 2
        @(posedge vSync);
        @(negedge iClk);
        writeReg(`REG_ENABLE_BASE + 0, 0);
        setLayer(1, 8, 40, 10, 30, randomColour());
        setLayer(3, 20, 50, 20, 40, randomColour());
        setLayer(2, 0, 63, 0, 47, randomColour());
        writeReg(`REG_ENABLE_BASE + 2, 32'h00FFFFFE);  // bit 0 clear
        writeReg(`REG_ENABLE_BASE + 1, 1);
        writeReg(`REG_ENABLE_BASE + 3, 1);

        // move layer 1 mid frame 3 so frame 4 shows it
        @(negedge vSync);
        repeat (20) @(negedge de);
        @(negedge iClk);
        setLayer(1, 2, 12, 30, 45, randomColour());

        // frame 4 adds an inverted layer 0 and a layer 2 past the right edge
        @(posedge vSync);
        @(negedge iClk);
        setLayer(0, 40, 20, 0, 47, randomColour());
        writeReg(`REG_ENABLE_BASE + 0, 1);
        setLayer(2, 60, 200, 10, 15, randomColour());
        writeReg(`REG_ENABLE_BASE + 2, 1);

        @(posedge vSync);                   // end of frame 4
        repeat (4) @(negedge iClk);
        if (framesSeen != 4)
        begin
            $display("CHECK FAILED at %0t: saw %0d frames, expected 4", $time, framesSeen);
            errCount++;
        end
        $display("cycles checked: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- rectOverlayTop.f
+incdir+common
common/overlayPkg.sv
verilog/videoTiming.sv
overlay/rectLayer.sv
overlay/layerRegs.sv
overlay/layerMixer.sv
verilog/rectOverlayTop.sv
bench/rectOverlayTb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the rectangle overlay testbench with Verilator and run it.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -f rectOverlayTop.f \
    --top-module rectOverlayTb -o rectOverlayTb_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/rectOverlayTb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "tests failed" "$SIM_LOG"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0
